/* rtl/conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

  // window and buffer geometry
  localparam int WINDOW_PHASES = 18; // one mux input per phase
  localparam int FEATURE_HALF  = 9;  // next-feature entries are written two at a time
  localparam int KERNEL_BANKS  = 16;
  localparam int OUT_CHANNELS  = 16;

  typedef logic [6:0] coord_t;     // feature map coordinate, maps up to 128
  typedef logic [4:0] phase_t;     // compute phase, mux select and kernel address
  typedef logic [2:0] bank_pair_t; // kernel bank pair index
  typedef logic [3:0] ch_t;        // output channel

  typedef enum logic [1:0] {
    STRIDE_1 = 2'd0,
    STRIDE_2 = 2'd1,
    STRIDE_4 = 2'd2  // value 3 is reserved
  } stride_mode_e;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_KERNEL,  // 8 bank pairs x 18 addresses
    FETCH_FEATURE, // first 18 feature words, two per cycle
    WRITE_THROUGH, // next buffer into working buffer
    COMPUTE,       // 18 phases per output position
    WRITEBACK      // drain the channels of the last position
  } ctrl_state_e;

  typedef struct packed {
    phase_t                  read_addr;
    logic                    re;
    phase_t                  write_addr;
    logic [KERNEL_BANKS-1:0] bank_we;
  } kernel_ctrl_t;

  typedef struct packed {
    phase_t mux_sel;
    logic   valid;
    logic   accumulate; // low restarts the accumulators
  } mac_ctrl_t;

  typedef struct packed {
    logic [WINDOW_PHASES-1:0] next_we;
    logic                     feature_we; // next buffer to working buffer
    logic                     output_we;  // latch the mac results
  } feature_ctrl_t;

  typedef struct packed {
    logic   valid;
    coord_t x;
    coord_t y;
    ch_t    ch;
  } out_beat_t;

endpackage

/* rtl/conv_sequencer.sv */
`timescale 1ns/1ps

module conv_sequencer import conv_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        arst_n_in,
  input  logic        start,
  input  logic        kernel_done,
  input  logic        last_pos,
  output ctrl_state_e state,
  output phase_t      phase,
  output logic        running
);

  localparam phase_t LAST_WINDOW_PHASE = phase_t'(WINDOW_PHASES - 1);
  localparam phase_t LAST_FEATURE_PHASE = phase_t'(FEATURE_HALF - 1);
  localparam phase_t LAST_DRAIN_PHASE = phase_t'(OUT_CHANNELS - 1);

  ctrl_state_e state_next;
  logic        phase_count_en;
  logic        phase_wrap;

  assign running = (state != IDLE);

  // the phase counter only paces the states that follow a fixed table
  assign phase_count_en = (state == FETCH_FEATURE) || (state == COMPUTE) ||
                          (state == WRITEBACK);
  assign phase_wrap = (state == COMPUTE) && (phase == LAST_WINDOW_PHASE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) state_next = FETCH_KERNEL;
      end
      FETCH_KERNEL: begin
        if (kernel_done) state_next = FETCH_FEATURE;
      end
      FETCH_FEATURE: begin
        if (phase == LAST_FEATURE_PHASE) state_next = WRITE_THROUGH;
      end
      WRITE_THROUGH: begin
        state_next = COMPUTE;
      end
      COMPUTE: begin
        // the window of the last position ends the sweep
        if (phase_wrap && last_pos) state_next = WRITEBACK;
      end
      WRITEBACK: begin
        if (phase == LAST_DRAIN_PHASE) state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      phase <= '0;
    end else if (state_next != state) begin
      phase <= '0; // every state starts at phase 0
    end else if (phase_count_en) begin
      if (phase_wrap) begin
        phase <= '0; // next window
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

endmodule

/* rtl/kernel_load_ctrl.sv */
`timescale 1ns/1ps

module kernel_load_ctrl import conv_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         arst_n_in,
  input  ctrl_state_e  state,
  input  phase_t       phase,
  output logic         kernel_done,
  output kernel_ctrl_t kernel_ctrl
);

  localparam bank_pair_t LAST_PAIR = bank_pair_t'(KERNEL_BANKS / 2 - 1);
  localparam phase_t LAST_ADDR = phase_t'(WINDOW_PHASES - 1);

  bank_pair_t pair;
  phase_t     waddr;
  logic       fetching;
  logic       last_addr;

  assign fetching  = (state == FETCH_KERNEL);
  assign last_addr = (waddr == LAST_ADDR);

  assign kernel_done = fetching && last_addr && (pair == LAST_PAIR);

  // address runs fastest, one bank pair per 18 words
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      pair  <= '0;
      waddr <= '0;
    end else if (!fetching) begin
      pair  <= '0;
      waddr <= '0;
    end else if (last_addr) begin
      waddr <= '0;
      pair  <= pair + 1'b1; // wraps to 0 after the last pair
    end else begin
      waddr <= waddr + 1'b1;
    end
  end

  always_comb begin
    kernel_ctrl            = '0;
    kernel_ctrl.write_addr = waddr;
    if (fetching) begin
      // banks 2b and 2b+1 share one coefficient word
      kernel_ctrl.bank_we = KERNEL_BANKS'(2'b11) << {pair, 1'b0};
    end
    if (state == COMPUTE) begin
      kernel_ctrl.re        = 1'b1;
      kernel_ctrl.read_addr = phase; // coefficient for this mux input
    end
  end

endmodule

/* rtl/scan_position.sv */
`timescale 1ns/1ps

module scan_position import conv_ctrl_pkg::*; #(
  parameter int FEATURE_MAP_WIDTH  = 128,
  parameter int FEATURE_MAP_HEIGHT = 128
) (
  input  logic         clk,
  input  logic         arst_n_in,
  input  ctrl_state_e  state,
  input  phase_t       phase,
  input  stride_mode_e stride_mode,
  output logic         last_pos,
  output logic         first_pos,
  output coord_t       out_x,
  output coord_t       out_y
);

  coord_t x;
  coord_t y;
  coord_t step;
  logic   last_x;
  logic   last_y;
  logic   window_end;

  always_comb begin
    case (stride_mode)
      STRIDE_1: step = coord_t'(1);
      STRIDE_2: step = coord_t'(2);
      STRIDE_4: step = coord_t'(4);
      default:  step = coord_t'(1); // reserved mode
    endcase
  end

  // last step on an axis is the first one within a stride of the edge
  assign last_x = (int'(x) + int'(step)) >= FEATURE_MAP_WIDTH;
  assign last_y = (int'(y) + int'(step)) >= FEATURE_MAP_HEIGHT;

  assign last_pos  = last_x && last_y;
  assign first_pos = (x == '0) && (y == '0);

  assign window_end = (state == COMPUTE) && (phase == phase_t'(WINDOW_PHASES - 1));

  // y inner, x outer
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      x <= '0;
      y <= '0;
    end else if (state == IDLE) begin
      x <= '0;
      y <= '0;
    end else if (window_end) begin
      y <= last_y ? coord_t'(0) : y + step;
      if (last_y) begin
        x <= last_x ? coord_t'(0) : x + step;
      end
    end
  end

  // results of the finished window leave during the next window
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      out_x <= '0;
      out_y <= '0;
    end else if (window_end) begin
      out_x <= x;
      out_y <= y;
    end
  end

endmodule

/* rtl/window_ctrl.sv */
`timescale 1ns/1ps

module window_ctrl import conv_ctrl_pkg::*; (
  input  ctrl_state_e   state,
  input  phase_t        phase,
  input  logic          first_pos,
  input  coord_t        out_x,
  input  coord_t        out_y,
  output logic          a_ready,
  output mac_ctrl_t     mac_ctrl,
  output feature_ctrl_t feature_ctrl,
  output out_beat_t     out_beat
);

  localparam phase_t LAST_PHASE = phase_t'(WINDOW_PHASES - 1);

  logic [WINDOW_PHASES-1:0] pair_we;
  logic                     load_phase;

  // entries p and p+9 are written together from one input word
  assign pair_we = (WINDOW_PHASES'(1) << phase) |
                   (WINDOW_PHASES'(1) << (int'(phase) + FEATURE_HALF));

  assign load_phase = (int'(phase) < FEATURE_HALF);

  always_comb begin
    a_ready      = 1'b0;
    mac_ctrl     = '0;
    feature_ctrl = '0;
    out_beat.valid = 1'b0;
    out_beat.x     = out_x;
    out_beat.y     = out_y;
    out_beat.ch    = ch_t'(phase);

    case (state)
      FETCH_KERNEL: begin
        a_ready = 1'b1; // one coefficient word per cycle
      end

      FETCH_FEATURE: begin
        a_ready = load_phase;
        if (load_phase) feature_ctrl.next_we = pair_we;
      end

      WRITE_THROUGH: begin
        feature_ctrl.feature_we = 1'b1;
      end

      COMPUTE: begin
        mac_ctrl.mux_sel    = phase;
        mac_ctrl.valid      = (phase != LAST_PHASE);
        mac_ctrl.accumulate = (phase != '0); // phase 0 starts a new sum

        // prefetch of the next window overlaps the first half
        a_ready = load_phase;
        if (load_phase) feature_ctrl.next_we = pair_we;

        // previous position streams out, nothing to send in the first window
        out_beat.valid = (int'(phase) < OUT_CHANNELS) && !first_pos;

        if (phase == LAST_PHASE) begin
          feature_ctrl.feature_we = 1'b1;
          feature_ctrl.output_we  = 1'b1;
        end
      end

      WRITEBACK: begin
        out_beat.valid = 1'b1; // drain of the last position
      end

      default: begin
      end
    endcase
  end

endmodule

/* rtl/conv_controller_top.sv */
`timescale 1ns/1ps

module conv_controller_top import conv_ctrl_pkg::*; #(
  parameter int FEATURE_MAP_WIDTH  = 128,
  parameter int FEATURE_MAP_HEIGHT = 128
) (
  input  logic          clk,
  input  logic          arst_n_in,
  input  logic          start,
  input  stride_mode_e  stride_mode, // held while running
  output logic          running,
  output logic          a_ready,
  output kernel_ctrl_t  kernel_ctrl,
  output mac_ctrl_t     mac_ctrl,
  output feature_ctrl_t feature_ctrl,
  output out_beat_t     out_beat
);

  ctrl_state_e state;
  phase_t      phase;
  logic        kernel_done;
  logic        last_pos;
  logic        first_pos;
  coord_t      out_x;
  coord_t      out_y;

  conv_sequencer sequencer_i (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .start       (start),
    .kernel_done (kernel_done),
    .last_pos    (last_pos),
    .state       (state),
    .phase       (phase),
    .running     (running)
  );

  kernel_load_ctrl kernel_load_i (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .state       (state),
    .phase       (phase),
    .kernel_done (kernel_done),
    .kernel_ctrl (kernel_ctrl)
  );

  scan_position #(
    .FEATURE_MAP_WIDTH  (FEATURE_MAP_WIDTH),
    .FEATURE_MAP_HEIGHT (FEATURE_MAP_HEIGHT)
  ) scan_i (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .state       (state),
    .phase       (phase),
    .stride_mode (stride_mode),
    .last_pos    (last_pos),
    .first_pos   (first_pos),
    .out_x       (out_x),
    .out_y       (out_y)
  );

  window_ctrl window_i (
    .state        (state),
    .phase        (phase),
    .first_pos    (first_pos),
    .out_x        (out_x),
    .out_y        (out_y),
    .a_ready      (a_ready),
    .mac_ctrl     (mac_ctrl),
    .feature_ctrl (feature_ctrl),
    .out_beat     (out_beat)
  );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk; // free running, first rising edge at half a period
    end
  end

endmodule

/* bench/conv_controller_tb.sv */
`timescale 1ns/1ps

module conv_controller_tb import conv_ctrl_pkg::*; ();

  localparam int MAP_SIZE      = 8;
  localparam int DRIVE_DELAY   = 2;
  localparam int KERNEL_CYCLES = (KERNEL_BANKS / 2) * WINDOW_PHASES;
  localparam int COMPUTE_START = KERNEL_CYCLES + FEATURE_HALF + 1; // after write-through

  logic          clk;
  logic          arst_n_in;
  logic          start;
  stride_mode_e  stride_mode;
  logic          running;
  logic          a_ready;
  kernel_ctrl_t  kernel_ctrl;
  mac_ctrl_t     mac_ctrl;
  feature_ctrl_t feature_ctrl;
  out_beat_t     out_beat;

  int   errors;
  int   checks;
  int   beats;
  logic aborted;

  tb_clock_gen #(.PERIOD_NS(40)) clock_i (.clk(clk));

  conv_controller_top #(
    .FEATURE_MAP_WIDTH  (MAP_SIZE),
    .FEATURE_MAP_HEIGHT (MAP_SIZE)
  ) dut_i (
    .clk          (clk),
    .arst_n_in    (arst_n_in),
    .start        (start),
    .stride_mode  (stride_mode),
    .running      (running),
    .a_ready      (a_ready),
    .kernel_ctrl  (kernel_ctrl),
    .mac_ctrl     (mac_ctrl),
    .feature_ctrl (feature_ctrl),
    .out_beat     (out_beat)
  );

  // number of positions along one axis
  function automatic int axis_count(int size, int step);
    int n;
    int coord;
    n = 1;
    coord = 0;
    while (coord < size - step) begin
      coord += step;
      n++;
    end
    return n;
  endfunction

  function automatic stride_mode_e mode_for_step(int step);
    case (step)
      2:       return STRIDE_2;
      4:       return STRIDE_4;
      default: return STRIDE_1;
    endcase
  endfunction

  function automatic logic [WINDOW_PHASES-1:0] feature_pair(int k);
    logic [WINDOW_PHASES-1:0] v;
    v = '0;
    v[k] = 1'b1;
    v[k + FEATURE_HALF] = 1'b1; // second half of the buffer
    return v;
  endfunction

  task automatic check_kernel(string tag, kernel_ctrl_t exp, kernel_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s kernel_ctrl expected %h actual %h", tag, exp, act);
    end
  endtask

  task automatic check_mac(string tag, mac_ctrl_t exp, mac_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s mac_ctrl expected %h actual %h", tag, exp, act);
    end
  endtask

  task automatic check_feature(string tag, feature_ctrl_t exp, feature_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s feature_ctrl expected %h actual %h", tag, exp, act);
    end
  endtask

  // position and channel only matter on a valid beat
  task automatic check_beat(string tag, out_beat_t exp, out_beat_t act);
    checks++;
    if (act.valid !== exp.valid ||
        (exp.valid && (act.x !== exp.x || act.y !== exp.y || act.ch !== exp.ch))) begin
      errors++;
      $display("FAIL %s out_beat expected %h actual %h", tag, exp, act);
    end
  endtask

  task automatic check_flag(string tag, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %b actual %b", tag, exp, act);
    end
  endtask

  task automatic check_count(string tag, int exp, int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", tag, exp, act);
    end
  endtask

  task automatic check_idle(string tag);
    out_beat_t no_beat;
    no_beat = '0;
    check_flag({tag, " running"}, 1'b0, running);
    check_flag({tag, " a_ready"}, 1'b0, a_ready);
    check_kernel(tag, '0, kernel_ctrl);
    check_mac(tag, '0, mac_ctrl);
    check_feature(tag, '0, feature_ctrl);
    check_beat(tag, no_beat, out_beat);
  endtask

  // expected outputs for cycle c of a run, counted from the first running cycle
  task automatic expect_cycle(string name, int c, int n_pos, int ny, int step);
    kernel_ctrl_t  ek;
    mac_ctrl_t     em;
    feature_ctrl_t ef;
    out_beat_t     eb;
    logic          ea;
    int            w;
    int            p;
    int            pos;
    int            pair;
    string         tag;
    ek  = '0;
    em  = '0;
    ef  = '0;
    eb  = '0;
    ea  = 1'b0;
    pos = -1;
    tag = $sformatf("%s cycle %0d", name, c);
    if (c < KERNEL_CYCLES) begin
      pair = c / WINDOW_PHASES;
      ek.write_addr          = phase_t'(c % WINDOW_PHASES);
      ek.bank_we[2 * pair]     = 1'b1;
      ek.bank_we[2 * pair + 1] = 1'b1;
      ea                     = 1'b1;
    end else if (c < KERNEL_CYCLES + FEATURE_HALF) begin
      ef.next_we = feature_pair(c - KERNEL_CYCLES);
      ea         = 1'b1;
    end else if (c < COMPUTE_START) begin
      ef.feature_we = 1'b1; // write-through
    end else if (c < COMPUTE_START + WINDOW_PHASES * n_pos) begin
      w = (c - COMPUTE_START) / WINDOW_PHASES;
      p = (c - COMPUTE_START) % WINDOW_PHASES;
      ek.re         = 1'b1;
      ek.read_addr  = phase_t'(p);
      em.mux_sel    = phase_t'(p);
      em.valid      = (p <= 16);
      em.accumulate = (p != 0);
      if (p < FEATURE_HALF) begin
        ea         = 1'b1;
        ef.next_we = feature_pair(p);
      end
      if (p == WINDOW_PHASES - 1) begin
        ef.feature_we = 1'b1;
        ef.output_we  = 1'b1;
      end
      if (p < OUT_CHANNELS && w > 0) pos = w - 1; // previous window streams out
    end else begin
      p = c - COMPUTE_START - WINDOW_PHASES * n_pos;
      if (p < OUT_CHANNELS) pos = n_pos - 1; // drain
    end
    if (pos >= 0) begin
      eb.valid = 1'b1;
      eb.x     = coord_t'((pos / ny) * step);
      eb.y     = coord_t'((pos % ny) * step);
      eb.ch    = ch_t'(p);
    end
    if (out_beat.valid === 1'b1) beats++;
    check_flag({tag, " a_ready"}, ea, a_ready);
    check_kernel(tag, ek, kernel_ctrl);
    check_mac(tag, em, mac_ctrl);
    check_feature(tag, ef, feature_ctrl);
    check_beat(tag, eb, out_beat);
  endtask

  task automatic run_test(string name, int step, int exp_beats, int exp_cycles);
    int ny;
    int n_pos;
    int cycles;
    int limit;
    ny     = axis_count(MAP_SIZE, step);
    n_pos  = axis_count(MAP_SIZE, step) * ny;
    limit  = exp_cycles + 200;
    beats  = 0;
    cycles = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    stride_mode = mode_for_step(step);
    start       = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    start = 1'b0;
    @(negedge clk);
    while (running === 1'b1 && cycles < limit) begin
      expect_cycle(name, cycles, n_pos, ny, step);
      cycles++;
      @(negedge clk);
    end
    if (cycles >= limit) begin
      errors++;
      aborted = 1'b1;
      $display("%s: running did not fall within %0d cycles", name, limit);
      return;
    end
    check_count({name, " running cycles"}, exp_cycles, cycles);
    check_count({name, " output beats"}, exp_beats, beats);
    check_idle({name, " after run"});
  endtask

  initial begin
    int    fd;
    int    code;
    int    step;
    int    exp_beats;
    int    exp_cycles;
    int    n_tests;
    string line;
    string name;
    errors      = 0;
    checks      = 0;
    beats       = 0;
    n_tests     = 0;
    aborted     = 1'b0;
    start       = 1'b0;
    stride_mode = STRIDE_1;
    arst_n_in   = 1'b0;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    arst_n_in = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_idle("after reset");
    end

    fd = $fopen("bench/conv_ctrl_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test file bench/conv_ctrl_tests.txt");
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue; // comments and blank lines
        code = $sscanf(line, "%s %d %d %d", name, step, exp_beats, exp_cycles);
        if (code != 4 || !(step == 1 || step == 2 || step == 4)) begin
          errors++;
          $display("malformed line in the test file: %s", line);
          continue;
        end
        n_tests++;
        run_test(name, step, exp_beats, exp_cycles);
      end
      $fclose(fd);
      if (n_tests == 0) begin
        errors++;
        $display("the test file holds no tests");
      end
    end

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* bench/conv_ctrl_tests.txt */
# each line holds the test name, the stride step (1, 2 or 4)
# then the expected output beats and the expected running cycles on an 8x8 map
stride_1 1 1024 1322
stride_4 4 64 242
stride_2 2 256 458

/* project.f */
rtl/conv_ctrl_pkg.sv
rtl/conv_sequencer.sv
rtl/kernel_load_ctrl.sv
rtl/scan_position.sv
rtl/window_ctrl.sv
rtl/conv_controller_top.sv
bench/tb_clock_gen.sv
bench/conv_controller_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := conv_controller_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_MSG   := Regression passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
